//--- rtl/icache_pkg.sv
package icache_pkg;

    // address split
    localparam int ADDR_BITS   = 32;          // byte address width on both buses
    localparam int OFFSET_BITS = 4;           // 16-byte line

    // line geometry
    localparam int WAYS       = 4;            // fixed by the way-match logic
    localparam int LINE_BITS  = 128;          // data bits per line
    localparam int WORD_BITS  = 32;           // wishbone data width
    localparam int LINE_WORDS = LINE_BITS / WORD_BITS; // beats per fill

    // per-set control word
    //   [3:0] valid flags of ways 0..3
    //   [4]   0 -> victim in ways 0/1, 1 -> victim in ways 2/3
    //   [5]   victim inside ways 0/1 (0 -> way 0)
    //   [6]   victim inside ways 2/3 (0 -> way 2)
    localparam int CTRL_BITS      = 7;
    localparam int CTRL_VALID_LSB = 0;        // valid bit of way w sits at lsb + w
    localparam int CTRL_PAIR      = 4;        // tree root
    localparam int CTRL_LOW       = 5;        // left leaf
    localparam int CTRL_HIGH      = 6;        // right leaf

endpackage

//--- rtl/icache_matched.sv
`timescale 1ns/1ps

module icache_matched import icache_pkg::*; #(
    parameter int INDEX_BITS = 8
) (
    input  logic [ADDR_BITS-1:0]                        address,
    input  logic [CTRL_BITS-1:0]                        control,
    input  logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] data_0,
    input  logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] data_1,
    input  logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] data_2,
    input  logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] data_3,
    output logic                                        matched,
    output logic [LINE_BITS-1:0]                        matched_data_line,
    output logic [1:0]                                  plru_index,
    output logic [CTRL_BITS-1:0]                        control_after_invalidate_write,
    output logic [CTRL_BITS-1:0]                        control_after_match,
    output logic [CTRL_BITS-1:0]                        control_after_line_read
);

    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
    localparam int LINE_W   = TAG_BITS + LINE_BITS;

    logic [LINE_W-1:0]   way_line [WAYS];       // tag on top, data below
    logic [TAG_BITS-1:0] addr_tag;
    logic [1:0]          hit_way;               // lowest matching way

    // move the tree away from the way just used
    function automatic logic [CTRL_BITS-1:0] touch(input logic [CTRL_BITS-1:0] c,
                                                   input logic [1:0] way);
        logic [CTRL_BITS-1:0] n;
        n = c;
        case (way)
            2'd0: begin                         // next victim in 2/3, then 1
                n[CTRL_PAIR] = 1'b1;
                n[CTRL_LOW]  = 1'b1;
            end
            2'd1: begin
                n[CTRL_PAIR] = 1'b1;
                n[CTRL_LOW]  = 1'b0;
            end
            2'd2: begin                         // next victim in 0/1, then 3
                n[CTRL_PAIR] = 1'b0;
                n[CTRL_HIGH] = 1'b1;
            end
            default: begin
                n[CTRL_PAIR] = 1'b0;
                n[CTRL_HIGH] = 1'b0;
            end
        endcase
        return n;
    endfunction

    assign way_line[0] = data_0;
    assign way_line[1] = data_1;
    assign way_line[2] = data_2;
    assign way_line[3] = data_3;
    assign addr_tag    = address[ADDR_BITS-1 -: TAG_BITS];

    // tag compare scanned downwards so the lowest hit wins
    always_comb begin
        matched = 1'b0;
        hit_way = 2'd0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (control[CTRL_VALID_LSB + w] && way_line[w][LINE_W-1 -: TAG_BITS] == addr_tag) begin
                matched = 1'b1;
                hit_way = 2'(w);
            end
        end
    end

    assign matched_data_line = way_line[hit_way][LINE_BITS-1:0]; // don't care when no hit

    // victim choice where an empty way beats the tree
    always_comb begin
        if (!control[CTRL_PAIR])
            plru_index = control[CTRL_LOW] ? 2'd1 : 2'd0;
        else
            plru_index = control[CTRL_HIGH] ? 2'd3 : 2'd2;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!control[CTRL_VALID_LSB + w])
                plru_index = 2'(w);                          // lowest invalid way
        end
    end

    // next control words
    always_comb begin
        control_after_match            = touch(control, hit_way);
        control_after_invalidate_write = touch(control, hit_way);
        control_after_invalidate_write[CTRL_VALID_LSB + hit_way] = 1'b0; // drop the snooped line
        control_after_line_read        = touch(control, plru_index);
        control_after_line_read[CTRL_VALID_LSB + plru_index]     = 1'b1; // new line now valid
    end

endmodule

//--- rtl/icache_ram.sv
`timescale 1ns/1ps

module icache_ram import icache_pkg::*; #(
    parameter int INDEX_BITS = 8
) (
    input  logic                                             clk,
    input  logic [INDEX_BITS-1:0]                            rd_index,
    input  logic [INDEX_BITS-1:0]                            wr_index,
    input  logic [WAYS-1:0]                                  wr_way_en,
    input  logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] wr_line,
    input  logic                                             ctrl_wr_en,
    input  logic [CTRL_BITS-1:0]                             wr_ctrl,
    output logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] rd_line_0,
    output logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] rd_line_1,
    output logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] rd_line_2,
    output logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] rd_line_3,
    output logic [CTRL_BITS-1:0]                             rd_ctrl
);

    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
    localparam int LINE_W   = TAG_BITS + LINE_BITS;
    localparam int SETS     = 1 << INDEX_BITS;

    logic [CTRL_BITS-1:0] ctrl_mem [SETS];                   // valid + tree bits per set

    // one tag+data array per way, each with its own write enable
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        logic [LINE_W-1:0] line_mem [SETS];
        logic [LINE_W-1:0] rd_q;                             // registered read port

        always_ff @(posedge clk) begin
            if (wr_way_en[w])
                line_mem[wr_index] <= wr_line;
            rd_q <= line_mem[rd_index];                      // old data on a same-edge write
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_wr_en)
            ctrl_mem[wr_index] <= wr_ctrl;
        rd_ctrl <= ctrl_mem[rd_index];
    end

    assign rd_line_0 = g_way[0].rd_q;
    assign rd_line_1 = g_way[1].rd_q;
    assign rd_line_2 = g_way[2].rd_q;
    assign rd_line_3 = g_way[3].rd_q;

endmodule

//--- rtl/icache_fill.sv
`timescale 1ns/1ps

module icache_fill import icache_pkg::*; (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            fill_start,
    input  logic [ADDR_BITS-1:OFFSET_BITS]  fill_adr,  // line base
    output logic                            fill_done,
    output logic [LINE_BITS-1:0]            fill_line,
    output logic                            mem_cyc,
    output logic                            mem_stb,
    output logic [ADDR_BITS-1:0]            mem_adr,
    input  logic [WORD_BITS-1:0]            mem_dat,
    input  logic                            mem_ack
);

    localparam int BEAT_BITS = $clog2(LINE_WORDS);

    logic                           busy_q;   // burst in flight
    logic [BEAT_BITS-1:0]           beat_q;   // word being fetched
    logic                           done_q;
    logic [ADDR_BITS-1:OFFSET_BITS] base_q;
    logic [LINE_BITS-1:0]           line_q;   // assembled line
    logic                           take;     // accept a new request
    logic                           beat_ok;  // current beat acknowledged

    assign take    = !busy_q && fill_start;
    assign beat_ok = busy_q && mem_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            beat_q <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (take) begin
                busy_q <= 1'b1;
                beat_q <= '0;
            end else if (beat_ok) begin
                beat_q <= beat_q + 1'b1;
                if (&beat_q) begin                   // last beat, end of burst
                    busy_q <= 1'b0;
                    done_q <= 1'b1;                  // one cycle after final ack
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take)
            base_q <= fill_adr;
        if (beat_ok)
            line_q[beat_q*WORD_BITS +: WORD_BITS] <= mem_dat; // beat k -> bits 32k up
    end

    assign mem_cyc   = busy_q;                       // held over all beats
    assign mem_stb   = busy_q;                       // next beat follows straight after ack
    assign mem_adr   = {base_q, beat_q, 2'b00};      // base + 0, 4, 8, 12
    assign fill_done = done_q;
    assign fill_line = line_q;

endmodule

//--- rtl/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; #(
    parameter int INDEX_BITS = 8
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cpu_cyc,
    input  logic                            cpu_stb,
    input  logic [ADDR_BITS-1:2]            cpu_adr,
    output logic [WORD_BITS-1:0]            cpu_dat,
    output logic                            cpu_ack,
    input  logic                            snoop_stb,
    input  logic [ADDR_BITS-1:2]            snoop_adr,
    output logic                            snoop_ack,
    output logic [INDEX_BITS-1:0]           rd_index,
    output logic [INDEX_BITS-1:0]           wr_index,
    output logic [WAYS-1:0]                 wr_way_en,
    output logic [ADDR_BITS-OFFSET_BITS-INDEX_BITS+LINE_BITS-1:0] wr_line,
    output logic                            ctrl_wr_en,
    output logic [CTRL_BITS-1:0]            wr_ctrl,
    output logic [ADDR_BITS-1:0]            lookup_adr,
    input  logic                            matched,
    input  logic [LINE_BITS-1:0]            matched_line,
    input  logic [1:0]                      plru_index,
    input  logic [CTRL_BITS-1:0]            ctrl_after_invalidate,
    input  logic [CTRL_BITS-1:0]            ctrl_after_match,
    input  logic [CTRL_BITS-1:0]            ctrl_after_fill,
    output logic                            fill_start,
    output logic [ADDR_BITS-1:OFFSET_BITS]  fill_adr,
    input  logic                            fill_done,
    input  logic [LINE_BITS-1:0]            fill_line
);

    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - INDEX_BITS;
    localparam int IDX_LSB  = OFFSET_BITS;
    localparam int IDX_MSB  = OFFSET_BITS + INDEX_BITS - 1;

    localparam logic [2:0] S_CLEAR   = 3'd0;   // zero control words after reset
    localparam logic [2:0] S_IDLE    = 3'd1;
    localparam logic [2:0] S_READ    = 3'd2;   // bubble so a fresh write is read back
    localparam logic [2:0] S_COMPARE = 3'd3;   // ram data valid, matcher output used
    localparam logic [2:0] S_FILL    = 3'd4;
    localparam logic [2:0] S_WRITE   = 3'd5;   // control and line write, acks

    logic [2:0]            state_q;
    logic [INDEX_BITS-1:0] clear_cnt_q;
    logic [ADDR_BITS-1:2]  adr_q;              // address under lookup
    logic                  snoop_q;            // lookup came from the snoop port
    logic                  refill_q;           // write state stores a fetched line
    logic [ADDR_BITS-1:2]  in_adr;             // snoop has priority
    logic                  write_st;

    assign in_adr   = snoop_stb ? snoop_adr : cpu_adr;
    assign write_st = (state_q == S_WRITE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= S_CLEAR;
            clear_cnt_q <= '0;
            snoop_q     <= 1'b0;
            refill_q    <= 1'b0;
        end else begin
            case (state_q)
                S_CLEAR: begin
                    clear_cnt_q <= clear_cnt_q + 1'b1;
                    if (&clear_cnt_q)
                        state_q <= S_IDLE;           // last set cleared
                end
                S_IDLE: begin
                    if (snoop_stb || (cpu_cyc && cpu_stb)) begin
                        snoop_q <= snoop_stb;
                        state_q <= S_COMPARE;        // ram read started on this edge
                    end
                end
                S_READ:    state_q <= S_COMPARE;
                S_COMPARE: state_q <= (snoop_q || matched) ? S_WRITE : S_FILL;
                S_FILL: begin
                    if (fill_done) begin
                        refill_q <= 1'b1;
                        state_q  <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    refill_q <= 1'b0;
                    state_q  <= refill_q ? S_READ : S_IDLE; // after a fill look up again
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE)
            adr_q <= in_adr;
    end

    // ram side
    assign rd_index   = (state_q == S_IDLE) ? in_adr[IDX_MSB:IDX_LSB] : adr_q[IDX_MSB:IDX_LSB];
    assign wr_index   = (state_q == S_CLEAR) ? clear_cnt_q : adr_q[IDX_MSB:IDX_LSB];
    assign wr_way_en  = (write_st && refill_q) ? (WAYS'(1) << plru_index) : '0;
    assign wr_line    = {adr_q[ADDR_BITS-1 -: TAG_BITS], fill_line};
    assign ctrl_wr_en = (state_q == S_CLEAR)
                     || (write_st && (refill_q || !snoop_q || matched)); // snoop miss leaves set alone
    assign wr_ctrl    = (state_q == S_CLEAR) ? '0 :
                        refill_q             ? ctrl_after_fill :
                        snoop_q              ? ctrl_after_invalidate :
                                               ctrl_after_match;

    assign lookup_adr = {adr_q, 2'b00};

    // bus side
    assign cpu_ack   = write_st && !snoop_q && !refill_q;
    assign snoop_ack = write_st && snoop_q;
    assign cpu_dat   = matched_line[adr_q[3:2]*WORD_BITS +: WORD_BITS]; // word within line

    assign fill_start = (state_q == S_COMPARE) && !snoop_q && !matched;
    assign fill_adr   = adr_q[ADDR_BITS-1:OFFSET_BITS];

endmodule

//--- rtl/icache_top.sv
`timescale 1ns/1ps

module icache_top import icache_pkg::*; #(
    parameter int INDEX_BITS = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cpu_cyc,
    input  logic                  cpu_stb,
    input  logic [ADDR_BITS-1:2]  cpu_adr,
    output logic [WORD_BITS-1:0]  cpu_dat,
    output logic                  cpu_ack,
    input  logic                  snoop_stb,
    input  logic [ADDR_BITS-1:2]  snoop_adr,
    output logic                  snoop_ack,
    output logic                  mem_cyc,
    output logic                  mem_stb,
    output logic [ADDR_BITS-1:0]  mem_adr,
    input  logic [WORD_BITS-1:0]  mem_dat,
    input  logic                  mem_ack
);

    localparam int LINE_W = ADDR_BITS - OFFSET_BITS - INDEX_BITS + LINE_BITS; // tag + data

    logic [INDEX_BITS-1:0]          rd_index;
    logic [INDEX_BITS-1:0]          wr_index;
    logic [WAYS-1:0]                wr_way_en;
    logic [LINE_W-1:0]              wr_line;
    logic                           ctrl_wr_en;
    logic [CTRL_BITS-1:0]           wr_ctrl;
    logic [LINE_W-1:0]              rd_line_0;
    logic [LINE_W-1:0]              rd_line_1;
    logic [LINE_W-1:0]              rd_line_2;
    logic [LINE_W-1:0]              rd_line_3;
    logic [CTRL_BITS-1:0]           rd_ctrl;
    logic [ADDR_BITS-1:0]           lookup_adr;
    logic                           matched;
    logic [LINE_BITS-1:0]           matched_line;
    logic [1:0]                     plru_index;
    logic [CTRL_BITS-1:0]           ctrl_after_invalidate;
    logic [CTRL_BITS-1:0]           ctrl_after_match;
    logic [CTRL_BITS-1:0]           ctrl_after_fill;
    logic                           fill_start;
    logic [ADDR_BITS-1:OFFSET_BITS] fill_adr;
    logic                           fill_done;
    logic [LINE_BITS-1:0]           fill_line;

    icache_ctrl #(.INDEX_BITS(INDEX_BITS)) i_ctrl (
        .clk, .reset,
        .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_dat, .cpu_ack,
        .snoop_stb, .snoop_adr, .snoop_ack,
        .rd_index, .wr_index, .wr_way_en, .wr_line, .ctrl_wr_en, .wr_ctrl,
        .lookup_adr,
        .matched, .matched_line, .plru_index,
        .ctrl_after_invalidate, .ctrl_after_match, .ctrl_after_fill,
        .fill_start, .fill_adr, .fill_done, .fill_line
    );

    icache_ram #(.INDEX_BITS(INDEX_BITS)) i_ram (
        .clk,
        .rd_index, .wr_index, .wr_way_en, .wr_line, .ctrl_wr_en, .wr_ctrl,
        .rd_line_0, .rd_line_1, .rd_line_2, .rd_line_3, .rd_ctrl
    );

    icache_matched #(.INDEX_BITS(INDEX_BITS)) i_matched (
        .address                        (lookup_adr),
        .control                        (rd_ctrl),
        .data_0                         (rd_line_0),
        .data_1                         (rd_line_1),
        .data_2                         (rd_line_2),
        .data_3                         (rd_line_3),
        .matched                        (matched),
        .matched_data_line              (matched_line),
        .plru_index                     (plru_index),
        .control_after_invalidate_write (ctrl_after_invalidate),
        .control_after_match            (ctrl_after_match),
        .control_after_line_read        (ctrl_after_fill)
    );

    icache_fill i_fill (
        .clk, .reset,
        .fill_start, .fill_adr, .fill_done, .fill_line,
        .mem_cyc, .mem_stb, .mem_adr, .mem_dat, .mem_ack
    );

endmodule

//--- verif/icache_checker.sv
`timescale 1ns/1ps

module icache_checker (
    input logic clk,
    input logic reset,
    input logic cpu_stb,
    input logic cpu_ack,
    input logic snoop_ack,
    input logic mem_cyc,
    input logic mem_stb
);

    int violations = 0;                           // failed assertions so far

    cpu_ack_single: assert property (@(posedge clk) disable iff (reset) cpu_ack |=> !cpu_ack)
        else begin
            violations++;
            $error("cpu_ack high for more than one cycle");
        end

    snoop_ack_single: assert property (@(posedge clk) disable iff (reset)
        snoop_ack |=> !snoop_ack)
        else begin
            violations++;
            $error("snoop_ack high for more than one cycle");
        end

    stb_inside_cyc: assert property (@(posedge clk) disable iff (reset) mem_stb |-> mem_cyc)
        else begin
            violations++;
            $error("mem_stb raised outside a mem_cyc burst");
        end

    ack_needs_stb: assert property (@(posedge clk) disable iff (reset) cpu_ack |-> cpu_stb)
        else begin
            violations++;
            $error("cpu_ack without a pending cpu_stb");
        end

endmodule

bind icache_top icache_checker i_checker (
    .clk, .reset, .cpu_stb, .cpu_ack, .snoop_ack, .mem_cyc, .mem_stb
);

//--- verif/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int CLK_PERIOD  = 4;
    localparam int SETS        = 8;                       // INDEX_BITS = 3
    localparam int SEED        = 32'hf764_e5f9;
    localparam int ACK_LIMIT   = 60;                      // worst miss plus clearing
    localparam int MISS_CYCLES = 40;
    localparam int NUM_DATA    = 40;
    localparam int NUM_MIX     = 150;
    localparam int MAX_REQ     = NUM_DATA + 2 * NUM_MIX + 30; // directed tests stay under 30

    logic        clk;
    logic        reset;
    logic        cpu_cyc;
    logic        cpu_stb;
    logic [31:2] cpu_adr;
    logic [31:0] cpu_dat;
    logic        cpu_ack;
    logic        snoop_stb;
    logic [31:2] snoop_adr;
    logic        snoop_ack;
    logic        mem_cyc;
    logic        mem_stb;
    logic [31:0] mem_adr;
    logic [31:0] mem_dat;
    logic        mem_ack;

    integer      seed = SEED;                             // stimulus stream
    integer      mem_seed = SEED;                         // wait state stream
    int          errors = 0;
    int          err0 = 0;                                // errors before the running test
    int          cpu_reqs = 0;
    int          snoop_reqs = 0;
    int          cpu_acks = 0;
    int          snoop_acks = 0;
    int          burst_cnt = 0;
    logic        cyc_seen = 1'b0;
    logic [31:4] cur_line = '0;                           // line the running cpu read may fetch

    // reference cache holds line address per way, valid flags and tree bits per set
    logic [31:4] m_line [SETS][4];
    logic [3:0]  m_valid [SETS];
    logic        m_pair [SETS];                           // 1 -> victim in ways 2/3
    logic        m_low [SETS];                            // 1 -> way 1 inside 0/1
    logic        m_high [SETS];                           // 1 -> way 3 inside 2/3

    icache_top #(.INDEX_BITS(3)) i_dut (
        .clk, .reset,
        .cpu_cyc, .cpu_stb, .cpu_adr, .cpu_dat, .cpu_ack,
        .snoop_stb, .snoop_adr, .snoop_ack,
        .mem_cyc, .mem_stb, .mem_adr, .mem_dat, .mem_ack
    );

    function automatic logic [31:0] mem_word(input logic [31:0] byte_adr);
        return (byte_adr * 32'h9e37_79b1) ^ {byte_adr[15:0], byte_adr[31:16]} ^ 32'h0bad_c0de;
    endfunction

    function automatic logic [31:2] rand_wadr();
        logic [31:0] r;
        r = $random(seed);
        return {22'h000100, r[7:0]};                      // 8 tags per set for plenty of reuse
    endfunction

    function automatic int find_way(input logic [31:4] line);
        int s;
        s = int'(line[6:4]);
        for (int w = 0; w < 4; w++)
            if (m_valid[s][w] && m_line[s][w] == line)
                return w;                                 // lowest matching way
        return -1;
    endfunction

    function automatic int pick_victim(input int s);
        for (int w = 0; w < 4; w++)
            if (!m_valid[s][w])
                return w;                                 // empty way first
        if (!m_pair[s])
            return m_low[s] ? 1 : 0;
        return m_high[s] ? 3 : 2;
    endfunction

    task automatic touch_tree(input int s, input int w);
        if (w < 2) begin
            m_pair[s] = 1'b1;                             // point away from the used pair
            m_low[s]  = (w == 0);
        end else begin
            m_pair[s] = 1'b0;
            m_high[s] = (w == 2);
        end
    endtask

    task automatic value_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("FAILED time %0d ns: %s expected %h got %h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("ERROR time %0d ns: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name);
        $display("test %s finished, %0d errors", name, errors - err0);
        err0 = errors;
    endtask

    task automatic expect_quiet();
        assert ({cpu_ack, snoop_ack, mem_cyc, mem_stb} === 4'b0000)
            else note_failure("bus outputs active during reset or clearing");
    endtask

    task automatic cpu_read(input logic [31:2] wadr, output logic hit);
        int          s;
        int          w;
        int          b0;
        int          cycles;
        logic        exp_hit;
        logic [31:0] exp_dat;
        s = int'(wadr[6:4]);
        w = find_way(wadr[31:4]);
        exp_hit = (w >= 0);
        if (!exp_hit) begin
            w = pick_victim(s);
            m_line[s][w]  = wadr[31:4];
            m_valid[s][w] = 1'b1;
        end
        touch_tree(s, w);
        exp_dat  = mem_word({wadr, 2'b00});
        cur_line = wadr[31:4];
        b0       = burst_cnt;
        cpu_reqs++;
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_adr = wadr;
        cycles  = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ack && cycles < ACK_LIMIT);
        assert (cpu_ack === 1'b1) else note_failure("cpu read was never acknowledged");
        assert (cpu_dat === exp_dat) else value_mismatch("cpu_dat", exp_dat, cpu_dat);
        assert (burst_cnt - b0 == (exp_hit ? 0 : 1))
            else value_mismatch("memory bursts", 32'(exp_hit ? 0 : 1), 32'(burst_cnt - b0));
        hit = (burst_cnt == b0);                          // no burst seen means the cache hit
        @(negedge clk);                                   // ack seen at the edge, then release
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
    endtask

    task automatic snoop_line(input logic [31:2] wadr);
        int s;
        int w;
        int cycles;
        s = int'(wadr[6:4]);
        w = find_way(wadr[31:4]);
        if (w >= 0) begin
            touch_tree(s, w);
            m_valid[s][w] = 1'b0;                         // drop the snooped line
        end
        snoop_reqs++;
        snoop_stb = 1'b1;
        snoop_adr = wadr;
        cycles    = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!snoop_ack && cycles < ACK_LIMIT);
        assert (snoop_ack === 1'b1) else note_failure("snoop was never acknowledged");
        @(negedge clk);
        snoop_stb = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // memory model with 0 to 3 wait states per beat, checks the beat order
    initial begin
        int         wait_cnt;
        logic [1:0] beat;
        mem_ack  = 1'b0;
        mem_dat  = '0;
        wait_cnt = 0;
        beat     = 2'd0;
        forever begin
            @(negedge clk);
            if (!mem_cyc)
                beat = 2'd0;
            if (mem_cyc && mem_stb && wait_cnt == 0) begin
                assert (mem_adr === {cur_line, beat, 2'b00})
                    else value_mismatch("mem_adr", {cur_line, beat, 2'b00}, mem_adr);
                mem_ack  = 1'b1;
                mem_dat  = mem_word(mem_adr);
                beat     = beat + 2'd1;
                wait_cnt = $random(mem_seed) & 3;
            end else begin
                mem_ack = 1'b0;
                if (mem_cyc && wait_cnt > 0)
                    wait_cnt--;
            end
        end
    end

    always @(negedge clk) begin
        if (cpu_ack === 1'b1)
            cpu_acks++;
        if (snoop_ack === 1'b1)
            snoop_acks++;
        if (mem_cyc === 1'b1 && !cyc_seen)
            burst_cnt++;                                  // new burst starts
        cyc_seen = (mem_cyc === 1'b1);
    end

    initial begin
        #((MAX_REQ * MISS_CYCLES + SETS + 20) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        logic        hit;
        logic [31:2] a;
        logic [31:2] b;
        logic [31:4] victim;
        logic [31:0] r;
        reset     = 1'b1;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_adr   = '0;
        snoop_stb = 1'b0;
        snoop_adr = '0;
        victim    = '0;
        for (int s = 0; s < SETS; s++) begin
            m_valid[s] = 4'b0000;
            m_pair[s]  = 1'b0;
            m_low[s]   = 1'b0;
            m_high[s]  = 1'b0;
            for (int w = 0; w < 4; w++)
                m_line[s][w] = '0;
        end

        repeat (2) begin
            @(negedge clk);
            expect_quiet();
        end
        reset = 1'b0;
        repeat (SETS - 1) begin
            @(negedge clk);
            expect_quiet();                               // control words being cleared
        end
        for (int k = 0; k < 4; k++) begin
            a = rand_wadr();
            a[6:4] = 3'(k);
            cpu_read(a, hit);
            assert (!hit) else note_failure("read after reset hit without a memory burst");
        end
        end_test("reset");

        for (int k = 0; k < NUM_DATA; k++)
            cpu_read(rand_wadr(), hit);
        end_test("read_data");

        a = {22'h000300, 8'h10};
        cpu_read(a, hit);
        assert (!hit) else note_failure("fresh line hit without a memory burst");
        for (int k = 0; k < 4; k++) begin
            cpu_read({a[31:4], 2'(k)}, hit);               // every word of the same line
            assert (hit) else note_failure("cached line missed");
        end
        end_test("hit_miss");

        for (int t = 0; t < 5; t++) begin
            if (t == 4)
                victim = m_line[5][pick_victim(5)];       // set is full by now
            cpu_read({22'h000200, 3'(t), 3'd5, 2'd0}, hit);
        end
        for (int w = 0; w < 4; w++) begin
            cpu_read({m_line[5][w], 2'd0}, hit);
            assert (hit) else note_failure("kept line missed after replacement");
        end
        cpu_read({victim, 2'd0}, hit);
        assert (!hit) else note_failure("evicted line did not miss");
        end_test("replacement");

        a = {22'h000300, 8'h24};
        cpu_read(a, hit);
        snoop_line(a);
        cpu_read(a, hit);
        assert (!hit) else note_failure("read after snoop invalidate hit in the cache");
        a = {22'h000300, 8'h38};                          // set 6, cached
        b = {22'h000300, 8'hb8};                          // set 6, never read
        cpu_read(a, hit);
        snoop_line(b);
        cpu_read(a, hit);
        assert (hit) else note_failure("snoop of an uncached line dropped a cached one");
        end_test("snoop");

        for (int i = 0; i < NUM_MIX; i++) begin
            r = $random(seed);
            if (r[3:0] == 4'd0) begin
                snoop_line(rand_wadr());
            end else if (r[3:0] < 4'd4) begin
                a = rand_wadr();
                b = rand_wadr();
                fork
                    cpu_read(a, hit);
                    begin
                        @(negedge clk);                   // snoop arrives once the read is taken
                        snoop_line(b);
                    end
                join
            end else begin
                cpu_read(rand_wadr(), hit);
            end
        end
        assert (cpu_acks == cpu_reqs) else value_mismatch("cpu_ack count", cpu_reqs, cpu_acks);
        assert (snoop_acks == snoop_reqs)
            else value_mismatch("snoop_ack count", snoop_reqs, snoop_acks);
        assert (i_dut.i_checker.violations == 0)
            else note_failure("bus protocol assertions failed in the checker");
        end_test("mixed");

        $display("summary: %0d cpu reads, %0d snoops, %0d memory bursts, %0d errors",
                 cpu_reqs, snoop_reqs, burst_cnt, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

//--- sim.f
rtl/icache_pkg.sv
rtl/icache_matched.sv
rtl/icache_ram.sv
rtl/icache_fill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
verif/icache_checker.sv
verif/icache_tb.sv

//--- Makefile
VERILATOR  := verilator
TOP        := icache_tb
FILELIST   := sim.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert -Wall
RUN_ARGS   := +verilator+error+limit+1000
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Result: PASSED" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
